// ==== build.f ====
logic/rv32i_types.sv
logic/control_unit.sv
logic/regfile.sv
logic/alu.sv
logic/datapath.sv
verification/clock_gen.sv
verification/datapath_properties.sv
verification/datapath_tb.sv

// ==== logic/alu.sv ====
`timescale 1ns/1ps

module alu (
    input  rv32i_types::alu_ops                aluop,
    input  logic [rv32i_types::word_width-1:0] a,
    input  logic [rv32i_types::word_width-1:0] b,
    output logic [rv32i_types::word_width-1:0] f
);

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (aluop)
            rv32i_types::alu_add:  f = a + b;
            rv32i_types::alu_sub:  f = a - b;
            rv32i_types::alu_sll:  f = a << shamt;
            rv32i_types::alu_slt:  f = {31'd0, $signed(a) < $signed(b)};
            rv32i_types::alu_sltu: f = {31'd0, a < b};
            rv32i_types::alu_xor:  f = a ^ b;
            rv32i_types::alu_srl:  f = a >> shamt;
            // arithmetic shift keeps the sign bit
            rv32i_types::alu_sra:  f = $unsigned($signed(a) >>> shamt);
            rv32i_types::alu_or:   f = a | b;
            rv32i_types::alu_and:  f = a & b;
            default:               f = a + b;
        endcase
    end

endmodule

// ==== logic/control_unit.sv ====
`timescale 1ns/1ps

module control_unit (
    input  logic [rv32i_types::word_width-1:0] instr,
    output rv32i_types::alu_ops                alu_op,
    output logic                               alumux1_pc,
    output rv32i_types::alumux2_sel_t          alumux2_sel,
    output rv32i_types::regfilemux_sel_t       regfile_mux_sel,
    output logic                               load_regfile,
    output logic                               mem_read,
    output logic                               mem_write,
    output rv32i_types::mem_size_t             mem_size
);

    rv32i_types::rv32i_opcode opcode;
    rv32i_types::alu_ops      arith_op;
    logic [2:0]               funct3;
    logic [6:0]               funct7;

    assign opcode = rv32i_types::rv32i_opcode'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    // shared by register and immediate forms, sub only exists for op_reg
    always_comb begin
        case (funct3)
            rv32i_types::f3_add: begin
                if (opcode == rv32i_types::op_reg && funct7[5])
                    arith_op = rv32i_types::alu_sub;
                else
                    arith_op = rv32i_types::alu_add;
            end
            rv32i_types::f3_sll:  arith_op = rv32i_types::alu_sll;
            rv32i_types::f3_slt:  arith_op = rv32i_types::alu_slt;
            rv32i_types::f3_sltu: arith_op = rv32i_types::alu_sltu;
            rv32i_types::f3_xor:  arith_op = rv32i_types::alu_xor;
            rv32i_types::f3_sr: begin
                if (funct7[5])
                    arith_op = rv32i_types::alu_sra;
                else
                    arith_op = rv32i_types::alu_srl;
            end
            rv32i_types::f3_or:   arith_op = rv32i_types::alu_or;
            default:              arith_op = rv32i_types::alu_and;
        endcase
    end

    always_comb begin
        // bubble unless the opcode says otherwise
        alu_op          = rv32i_types::alu_add;
        alumux1_pc      = 1'b0;
        alumux2_sel     = rv32i_types::alumux2_rs2;
        regfile_mux_sel = rv32i_types::wb_alu;
        load_regfile    = 1'b0;
        mem_read        = 1'b0;
        mem_write       = 1'b0;
        mem_size        = rv32i_types::size_word;

        case (opcode)
            rv32i_types::op_lui: begin
                // rs1 is read as x0 by the datapath, so this is 0 + u_imm
                alumux2_sel  = rv32i_types::alumux2_u_imm;
                load_regfile = 1'b1;
            end
            rv32i_types::op_auipc: begin
                alumux1_pc   = 1'b1;
                alumux2_sel  = rv32i_types::alumux2_u_imm;
                load_regfile = 1'b1;
            end
            rv32i_types::op_imm: begin
                alu_op       = arith_op;
                alumux2_sel  = rv32i_types::alumux2_i_imm;
                load_regfile = 1'b1;
            end
            rv32i_types::op_reg: begin
                alu_op       = arith_op;
                load_regfile = 1'b1;
            end
            rv32i_types::op_load: begin
                alumux2_sel  = rv32i_types::alumux2_i_imm;
                load_regfile = 1'b1;
                mem_read     = 1'b1;
                case (funct3)
                    rv32i_types::f3_lw: regfile_mux_sel = rv32i_types::wb_lw;
                    rv32i_types::f3_lh: begin
                        regfile_mux_sel = rv32i_types::wb_lh;
                        mem_size        = rv32i_types::size_half;
                    end
                    rv32i_types::f3_lhu: begin
                        regfile_mux_sel = rv32i_types::wb_lhu;
                        mem_size        = rv32i_types::size_half;
                    end
                    rv32i_types::f3_lb: begin
                        regfile_mux_sel = rv32i_types::wb_lb;
                        mem_size        = rv32i_types::size_byte;
                    end
                    rv32i_types::f3_lbu: begin
                        regfile_mux_sel = rv32i_types::wb_lbu;
                        mem_size        = rv32i_types::size_byte;
                    end
                    default: begin
                        load_regfile = 1'b0;
                        mem_read     = 1'b0;
                    end
                endcase
            end
            rv32i_types::op_store: begin
                alumux2_sel = rv32i_types::alumux2_s_imm;
                mem_write   = 1'b1;
                case (funct3)
                    rv32i_types::f3_sw: mem_size = rv32i_types::size_word;
                    rv32i_types::f3_sh: mem_size = rv32i_types::size_half;
                    rv32i_types::f3_sb: mem_size = rv32i_types::size_byte;
                    default:            mem_write = 1'b0;
                endcase
            end
            default: ;
        endcase
    end

endmodule

// ==== logic/datapath.sv ====
`timescale 1ns/1ps

module datapath (
    input  logic                               clk,
    input  logic                               rst_n,
    output logic [rv32i_types::word_width-1:0] inst_addr,
    input  logic [rv32i_types::word_width-1:0] inst_rdata,
    output logic [rv32i_types::word_width-1:0] data_addr,
    output logic [rv32i_types::word_width-1:0] data_wdata,
    output logic [3:0]                         data_mbe,
    output logic                               data_read,
    output logic                               data_write,
    input  logic [rv32i_types::word_width-1:0] data_rdata
);

    // fetch and decode
    logic [rv32i_types::word_width-1:0] pc;
    logic [4:0]                         rs1_addr;
    logic [rv32i_types::word_width-1:0] rs1_val;
    logic [rv32i_types::word_width-1:0] rs2_val;
    rv32i_types::alu_ops                alu_op_id;
    logic                               alumux1_pc_id;
    rv32i_types::alumux2_sel_t          alumux2_sel_id;
    rv32i_types::regfilemux_sel_t       regfile_mux_sel_id;
    logic                               load_regfile_id;
    logic                               mem_read_id;
    logic                               mem_write_id;
    rv32i_types::mem_size_t             mem_size_id;

    // execute
    logic [rv32i_types::word_width-1:0] pc_ex;
    logic [rv32i_types::word_width-1:0] instr_ex;
    logic [rv32i_types::word_width-1:0] rs1_ex;
    logic [rv32i_types::word_width-1:0] rs2_ex;
    rv32i_types::alu_ops                alu_op_ex;
    logic                               alumux1_pc_ex;
    rv32i_types::alumux2_sel_t          alumux2_sel_ex;
    rv32i_types::regfilemux_sel_t       regfile_mux_sel_ex;
    logic                               load_regfile_ex;
    logic                               mem_read_ex;
    logic                               mem_write_ex;
    rv32i_types::mem_size_t             mem_size_ex;
    logic [rv32i_types::word_width-1:0] i_imm;
    logic [rv32i_types::word_width-1:0] s_imm;
    logic [rv32i_types::word_width-1:0] u_imm;
    logic [rv32i_types::word_width-1:0] alumux1_out;
    logic [rv32i_types::word_width-1:0] alumux2_out;
    logic [rv32i_types::word_width-1:0] alu_out;

    // memory
    logic [rv32i_types::word_width-1:0] alu_mem;
    logic [rv32i_types::word_width-1:0] rs2_mem;
    logic [4:0]                         rd_mem;
    rv32i_types::regfilemux_sel_t       regfile_mux_sel_mem;
    logic                               load_regfile_mem;
    logic                               mem_read_mem;
    logic                               mem_write_mem;
    rv32i_types::mem_size_t             mem_size_mem;
    logic [3:0]                         lane_mask;

    // writeback
    logic [rv32i_types::word_width-1:0] alu_wb;
    logic [rv32i_types::word_width-1:0] rdata_wb;
    logic [4:0]                         rd_wb;
    rv32i_types::regfilemux_sel_t       regfile_mux_sel_wb;
    logic                               load_regfile_wb;
    logic [7:0]                         load_byte;
    logic [15:0]                        load_half;
    logic [rv32i_types::word_width-1:0] regfilemux_out;

    always_ff @(posedge clk) begin
        if (!rst_n)
            pc <= rv32i_types::reset_pc;
        else
            pc <= pc + 32'd4;
    end

    assign inst_addr = pc;

    // lui reads x0 so the alu adds the immediate to zero
    assign rs1_addr = (inst_rdata[6:0] == rv32i_types::op_lui) ? 5'd0 : inst_rdata[19:15];

    control_unit i_control_unit (
        .instr           (inst_rdata),
        .alu_op          (alu_op_id),
        .alumux1_pc      (alumux1_pc_id),
        .alumux2_sel     (alumux2_sel_id),
        .regfile_mux_sel (regfile_mux_sel_id),
        .load_regfile    (load_regfile_id),
        .mem_read        (mem_read_id),
        .mem_write       (mem_write_id),
        .mem_size        (mem_size_id)
    );

    regfile i_regfile (
        .clk   (clk),
        .rst_n (rst_n),
        .load  (load_regfile_wb),
        .dest  (rd_wb),
        .in    (regfilemux_out),
        .src_a (rs1_addr),
        .src_b (inst_rdata[24:20]),
        .reg_a (rs1_val),
        .reg_b (rs2_val)
    );

    // stage control, cleared to bubbles
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            alu_op_ex           <= rv32i_types::alu_add;
            alumux1_pc_ex       <= 1'b0;
            alumux2_sel_ex      <= rv32i_types::alumux2_rs2;
            regfile_mux_sel_ex  <= rv32i_types::wb_alu;
            load_regfile_ex     <= 1'b0;
            mem_read_ex         <= 1'b0;
            mem_write_ex        <= 1'b0;
            mem_size_ex         <= rv32i_types::size_word;
            regfile_mux_sel_mem <= rv32i_types::wb_alu;
            load_regfile_mem    <= 1'b0;
            mem_read_mem        <= 1'b0;
            mem_write_mem       <= 1'b0;
            mem_size_mem        <= rv32i_types::size_word;
            regfile_mux_sel_wb  <= rv32i_types::wb_alu;
            load_regfile_wb     <= 1'b0;
        end else begin
            alu_op_ex           <= alu_op_id;
            alumux1_pc_ex       <= alumux1_pc_id;
            alumux2_sel_ex      <= alumux2_sel_id;
            regfile_mux_sel_ex  <= regfile_mux_sel_id;
            load_regfile_ex     <= load_regfile_id;
            mem_read_ex         <= mem_read_id;
            mem_write_ex        <= mem_write_id;
            mem_size_ex         <= mem_size_id;
            regfile_mux_sel_mem <= regfile_mux_sel_ex;
            load_regfile_mem    <= load_regfile_ex;
            mem_read_mem        <= mem_read_ex;
            mem_write_mem       <= mem_write_ex;
            mem_size_mem        <= mem_size_ex;
            regfile_mux_sel_wb  <= regfile_mux_sel_mem;
            load_regfile_wb     <= load_regfile_mem;
        end
    end

    // payload pipeline registers
    always_ff @(posedge clk) begin
        pc_ex    <= pc;
        instr_ex <= inst_rdata;
        rs1_ex   <= rs1_val;
        rs2_ex   <= rs2_val;
        alu_mem  <= alu_out;
        rs2_mem  <= rs2_ex;
        rd_mem   <= instr_ex[11:7];
        alu_wb   <= alu_mem;
        rdata_wb <= data_rdata;
        rd_wb    <= rd_mem;
    end

    assign i_imm = {{21{instr_ex[31]}}, instr_ex[30:20]};
    assign s_imm = {{21{instr_ex[31]}}, instr_ex[30:25], instr_ex[11:7]};
    assign u_imm = {instr_ex[31:12], 12'h000};

    assign alumux1_out = alumux1_pc_ex ? pc_ex : rs1_ex;

    always_comb begin
        case (alumux2_sel_ex)
            rv32i_types::alumux2_i_imm: alumux2_out = i_imm;
            rv32i_types::alumux2_s_imm: alumux2_out = s_imm;
            rv32i_types::alumux2_u_imm: alumux2_out = u_imm;
            default:                    alumux2_out = rs2_ex;
        endcase
    end

    alu i_alu (
        .aluop (alu_op_ex),
        .a     (alumux1_out),
        .b     (alumux2_out),
        .f     (alu_out)
    );

    // byte lanes from access size and low address bits
    always_comb begin
        case (mem_size_mem)
            rv32i_types::size_byte: lane_mask = 4'b0001 << alu_mem[1:0];
            rv32i_types::size_half: lane_mask = 4'b0011 << alu_mem[1:0];
            default:                lane_mask = 4'b1111;
        endcase
    end

    assign data_addr  = alu_mem;
    assign data_read  = mem_read_mem;
    assign data_write = mem_write_mem;
    assign data_mbe   = (mem_read_mem || mem_write_mem) ? lane_mask : 4'b0000;
    // store data moved up into its lanes
    assign data_wdata = rs2_mem << {alu_mem[1:0], 3'b000};

    // pick the addressed lane of the loaded word
    assign load_byte = rdata_wb[{alu_wb[1:0], 3'b000} +: 8];
    assign load_half = alu_wb[1] ? rdata_wb[31:16] : rdata_wb[15:0];

    always_comb begin
        case (regfile_mux_sel_wb)
            rv32i_types::wb_lw:  regfilemux_out = rdata_wb;
            rv32i_types::wb_lh:  regfilemux_out = {{16{load_half[15]}}, load_half};
            rv32i_types::wb_lhu: regfilemux_out = {16'd0, load_half};
            rv32i_types::wb_lb:  regfilemux_out = {{24{load_byte[7]}}, load_byte};
            rv32i_types::wb_lbu: regfilemux_out = {24'd0, load_byte};
            default:             regfilemux_out = alu_wb;
        endcase
    end

endmodule

// ==== logic/regfile.sv ====
`timescale 1ns/1ps

module regfile (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               load,
    input  logic [4:0]                         dest,
    input  logic [rv32i_types::word_width-1:0] in,
    input  logic [4:0]                         src_a,
    input  logic [4:0]                         src_b,
    output logic [rv32i_types::word_width-1:0] reg_a,
    output logic [rv32i_types::word_width-1:0] reg_b
);

    // x0 has no storage
    logic [rv32i_types::word_width-1:0] regs [1:31];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (load && dest != 5'd0) begin
            regs[dest] <= in;
        end
    end

    // no write-through, a write is visible the cycle after
    assign reg_a = (src_a == 5'd0) ? '0 : regs[src_a];
    assign reg_b = (src_b == 5'd0) ? '0 : regs[src_b];

endmodule

// ==== logic/rv32i_types.sv ====
package rv32i_types;

    // data and address width of the core
    localparam int word_width = 32;

    // first fetch address after reset
    localparam logic [word_width-1:0] reset_pc = 32'h0000_0000;

    // funct3 codes of the integer operations
    localparam logic [2:0] f3_add  = 3'b000;
    localparam logic [2:0] f3_sll  = 3'b001;
    localparam logic [2:0] f3_slt  = 3'b010;
    localparam logic [2:0] f3_sltu = 3'b011;
    localparam logic [2:0] f3_xor  = 3'b100;
    localparam logic [2:0] f3_sr   = 3'b101;
    localparam logic [2:0] f3_or   = 3'b110;
    localparam logic [2:0] f3_and  = 3'b111;

    // funct3 codes of loads and stores
    localparam logic [2:0] f3_lb  = 3'b000;
    localparam logic [2:0] f3_lh  = 3'b001;
    localparam logic [2:0] f3_lw  = 3'b010;
    localparam logic [2:0] f3_lbu = 3'b100;
    localparam logic [2:0] f3_lhu = 3'b101;
    localparam logic [2:0] f3_sb  = 3'b000;
    localparam logic [2:0] f3_sh  = 3'b001;
    localparam logic [2:0] f3_sw  = 3'b010;

    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011
    } rv32i_opcode;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and
    } alu_ops;

    // second ALU operand
    typedef enum logic [1:0] {
        alumux2_rs2,
        alumux2_i_imm,
        alumux2_s_imm,
        alumux2_u_imm
    } alumux2_sel_t;

    // writeback source
    typedef enum logic [2:0] {
        wb_alu,
        wb_lw,
        wb_lh,
        wb_lhu,
        wb_lb,
        wb_lbu
    } regfilemux_sel_t;

    typedef enum logic [1:0] {
        size_byte,
        size_half,
        size_word
    } mem_size_t;

endpackage

// ==== run.sh ====
#!/bin/sh
# build and run the datapath testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module datapath_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vdatapath_tb)
sim_status=$?
printf '%s\n' "$sim_out"

if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "Testbench passed"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1

// ==== verification/clock_gen.sv ====
`timescale 1ns/1ps

module clock_gen (
    output logic clk,
    output logic rst_n
);

    // 10 ns period
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // 16 rising edges in reset, released on a falling edge
    initial begin
        rst_n = 1'b0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

// ==== verification/datapath_properties.sv ====
`timescale 1ns/1ps

module datapath_properties (
    input logic                               clk,
    input logic                               rst_n,
    input logic [rv32i_types::word_width-1:0] data_addr,
    input logic [3:0]                         data_mbe,
    input logic                               data_read,
    input logic                               data_write
);

    // one data access per cycle
    a_one_strobe: assert property (@(posedge clk) !(data_read && data_write))
        else $error("data_read and data_write are high in the same cycle");

    a_write_mask: assert property (@(posedge clk) data_write |-> data_mbe != 4'b0000)
        else $error("data_write is high with an empty byte mask");

    a_word_align: assert property (@(posedge clk)
        (data_read || data_write) && data_mbe == 4'b1111 |-> data_addr[1:0] == 2'b00)
        else $error("word access to an unaligned address");

    // a two-lane mask must cover an aligned halfword
    a_half_align: assert property (@(posedge clk)
        (data_read || data_write) && data_mbe != 4'b1111 && $countones(data_mbe) > 1
        |-> data_mbe == 4'b0011 || data_mbe == 4'b1100)
        else $error("halfword access to an odd address");

    // sampled mid-cycle, after the reset edge has cleared the stages
    a_reset_quiet: assert property (@(negedge clk) !rst_n |-> !data_read && !data_write)
        else $error("data strobe high during reset");

endmodule

bind datapath datapath_properties i_properties (
    .clk        (clk),
    .rst_n      (rst_n),
    .data_addr  (data_addr),
    .data_mbe   (data_mbe),
    .data_read  (data_read),
    .data_write (data_write)
);

// ==== verification/datapath_tb.sv ====
`timescale 1ns/1ps

module datapath_tb;

    localparam int prog_len    = 200;
    // three nops and 31 closing stores follow the random part
    localparam int rand_len    = prog_len - 34;
    localparam int run_len     = prog_len + 6;
    localparam int watchdog_ns = (16 + prog_len + 20) * 10 * 2;

    logic        clk;
    logic        rst_n;
    logic [31:0] inst_addr;
    logic [31:0] inst_rdata;
    logic [31:0] data_addr;
    logic [31:0] data_wdata;
    logic [3:0]  data_mbe;
    logic        data_read;
    logic        data_write;
    logic [31:0] data_rdata;

    logic [31:0] imem [0:255];
    logic [31:0] dmem [0:63];
    logic [31:0] mdl_reg [0:31];
    logic [31:0] mdl_mem [0:63];
    int          last_wr [0:31];
    bit          exp_read [0:255];
    bit          exp_write [0:255];
    int          st_idx [$];
    logic [31:0] st_addr [$];
    logic [3:0]  st_mbe [$];
    logic [31:0] st_data [$];
    int          first_store;
    int          errors;
    int          checks;

    clock_gen i_clock_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    datapath i_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .inst_addr  (inst_addr),
        .inst_rdata (inst_rdata),
        .data_addr  (data_addr),
        .data_wdata (data_wdata),
        .data_mbe   (data_mbe),
        .data_read  (data_read),
        .data_write (data_write),
        .data_rdata (data_rdata)
    );

    function automatic logic [31:0] fill_word(input int i);
        return 32'(i) * 32'h9e37_79b1 + 32'h6a09_e667;
    endfunction

    function automatic logic [31:0] lane_bits(input logic [3:0] mbe);
        return {{8{mbe[3]}}, {8{mbe[2]}}, {8{mbe[1]}}, {8{mbe[0]}}};
    endfunction

    // integer result straight from the ISA definition
    function automatic logic [31:0] int_result(input logic [2:0] f3, input logic alt,
                                               input logic [31:0] a, input logic [31:0] b);
        case (f3)
            rv32i_types::f3_add:  return alt ? a - b : a + b;
            rv32i_types::f3_sll:  return a << b[4:0];
            rv32i_types::f3_slt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            rv32i_types::f3_sltu: return (a < b) ? 32'd1 : 32'd0;
            rv32i_types::f3_xor:  return a ^ b;
            rv32i_types::f3_sr:   return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            rv32i_types::f3_or:   return a | b;
            default:              return a & b;
        endcase
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, rv32i_types::op_reg};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [2:0] f3);
        return {imm[11:5], rs2, 5'd0, f3, imm[4:0], rv32i_types::op_store};
    endfunction

    // only registers whose write has retired, or x0
    function automatic logic [4:0] pick_src(input int k);
        logic [4:0] r;
        for (int t = 0; t < 16; t++) begin
            r = 5'($urandom_range(0, 31));
            if (r == 5'd0 || k - last_wr[r] >= 4)
                return r;
        end
        return 5'd0;
    endfunction

    // naturally aligned offset inside the 64-word data memory
    function automatic logic [11:0] aligned_offset(input logic [2:0] f3);
        logic [11:0] word_off;
        word_off = 12'($urandom_range(0, 63)) << 2;
        case (f3[1:0])
            2'b00:   return word_off + 12'($urandom_range(0, 3));
            2'b01:   return word_off + (12'($urandom_range(0, 1)) << 1);
            default: return word_off;
        endcase
    endfunction

    task automatic gen_program();
        int          kind;
        logic [4:0]  rd;
        logic [2:0]  f3;
        logic        alt;
        logic [11:0] imm;
        logic [31:0] word;
        for (int r = 0; r < 32; r++)
            last_wr[r] = -100;
        for (int a = 0; a < 256; a++)
            imem[a] = 32'h0;
        for (int k = 0; k < rand_len; k++) begin
            kind = $urandom_range(0, 9);
            rd   = 5'($urandom_range(1, 31));
            f3   = 3'($urandom_range(0, 7));
            alt  = 1'($urandom_range(0, 1));
            case (kind)
                0, 1, 2: begin
                    if (f3 != rv32i_types::f3_add && f3 != rv32i_types::f3_sr)
                        alt = 1'b0;
                    word = enc_r({1'b0, alt, 5'b0}, pick_src(k), pick_src(k), f3, rd);
                end
                3, 4, 5: begin
                    imm = 12'($urandom);
                    if (f3 == rv32i_types::f3_sll)
                        imm = {7'b0, imm[4:0]};
                    if (f3 == rv32i_types::f3_sr)
                        imm = {1'b0, alt, 5'b0, imm[4:0]};
                    word = enc_i(imm, pick_src(k), f3, rd, rv32i_types::op_imm);
                end
                6: word = {20'($urandom), rd, rv32i_types::op_lui};
                7: word = {20'($urandom), rd, rv32i_types::op_auipc};
                8: begin
                    case ($urandom_range(0, 4))
                        0:       f3 = rv32i_types::f3_lb;
                        1:       f3 = rv32i_types::f3_lh;
                        2:       f3 = rv32i_types::f3_lw;
                        3:       f3 = rv32i_types::f3_lbu;
                        default: f3 = rv32i_types::f3_lhu;
                    endcase
                    word = enc_i(aligned_offset(f3), 5'd0, f3, rd, rv32i_types::op_load);
                end
                default: begin
                    f3   = 3'($urandom_range(0, 2));
                    word = enc_s(aligned_offset(f3), pick_src(k), f3);
                end
            endcase
            imem[k] = word;
            if (kind != 9)
                last_wr[rd] = k;
        end
        for (int k = rand_len; k < rand_len + 3; k++)
            imem[k] = enc_i(12'd0, 5'd0, rv32i_types::f3_add, 5'd0, rv32i_types::op_imm);
        // dump every register to its own word
        for (int r = 1; r < 32; r++)
            imem[rand_len + 2 + r] = enc_s(12'(r * 4), 5'(r), rv32i_types::f3_sw);
    endtask

    // in-order ISA model, queues every store and marks strobe cycles
    task automatic run_model();
        logic [31:0] instr;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic [31:0] addr;
        logic [31:0] word;
        logic [31:0] wdata;
        logic [3:0]  mbe;
        logic [2:0]  f3;
        logic        writes;
        first_store = -1;
        for (int r = 0; r < 32; r++)
            mdl_reg[r] = 32'h0;
        for (int i = 0; i < 64; i++)
            mdl_mem[i] = fill_word(i);
        for (int c = 0; c < 256; c++) begin
            exp_read[c]  = 1'b0;
            exp_write[c] = 1'b0;
        end
        for (int k = 0; k < prog_len; k++) begin
            instr  = imem[k];
            a      = mdl_reg[instr[19:15]];
            b      = mdl_reg[instr[24:20]];
            f3     = instr[14:12];
            writes = 1'b1;
            res    = 32'h0;
            case (instr[6:0])
                rv32i_types::op_lui:   res = {instr[31:12], 12'h000};
                rv32i_types::op_auipc: res = 32'(k * 4) + {instr[31:12], 12'h000};
                rv32i_types::op_imm: begin
                    res = int_result(f3, f3 == rv32i_types::f3_sr && instr[30], a,
                                     {{20{instr[31]}}, instr[31:20]});
                end
                rv32i_types::op_reg:   res = int_result(f3, instr[30], a, b);
                rv32i_types::op_load: begin
                    addr = a + {{20{instr[31]}}, instr[31:20]};
                    word = mdl_mem[addr[7:2]] >> {addr[1:0], 3'b000};
                    case (f3)
                        rv32i_types::f3_lb:  res = {{24{word[7]}}, word[7:0]};
                        rv32i_types::f3_lbu: res = {24'h0, word[7:0]};
                        rv32i_types::f3_lh:  res = {{16{word[15]}}, word[15:0]};
                        rv32i_types::f3_lhu: res = {16'h0, word[15:0]};
                        default:             res = mdl_mem[addr[7:2]];
                    endcase
                    exp_read[k + 2] = 1'b1;
                end
                rv32i_types::op_store: begin
                    writes = 1'b0;
                    addr   = a + {{20{instr[31]}}, instr[31:25], instr[11:7]};
                    case (f3)
                        rv32i_types::f3_sb: mbe = 4'b0001 << addr[1:0];
                        rv32i_types::f3_sh: mbe = 4'b0011 << addr[1:0];
                        default:            mbe = 4'b1111;
                    endcase
                    wdata = (b << {addr[1:0], 3'b000}) & lane_bits(mbe);
                    mdl_mem[addr[7:2]] = (mdl_mem[addr[7:2]] & ~lane_bits(mbe)) | wdata;
                    st_idx.push_back(k);
                    st_addr.push_back(addr);
                    st_mbe.push_back(mbe);
                    st_data.push_back(wdata);
                    exp_write[k + 2] = 1'b1;
                    if (first_store < 0)
                        first_store = k;
                end
                default: writes = 1'b0;
            endcase
            if (writes && instr[11:7] != 5'd0)
                mdl_reg[instr[11:7]] = res;
        end
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        errors++;
        $display("Mismatch %s: expected 0x%08h, actual 0x%08h", name, exp, act);
    endtask

    task automatic report_error(input string msg);
        errors++;
        $display("Error: %s", msg);
    endtask

    // both memories answer combinationally, updated on the falling edge
    task automatic drive_memories();
        if (inst_addr[31:10] == 22'd0)
            inst_rdata = imem[inst_addr[9:2]];
        else
            inst_rdata = 32'h0;
        if (data_read)
            data_rdata = dmem[data_addr[7:2]];
        else
            data_rdata = 32'h0;
    endtask

    task automatic check_cycle(input int cyc);
        string name;
        if (data_read !== exp_read[cyc])
            report_error($sformatf("data_read is %b in cycle %0d", data_read, cyc));
        if (data_write && !exp_write[cyc]) begin
            if (cyc < first_store + 2)
                report_error($sformatf("data_write fired in cycle %0d, before any store", cyc));
            else
                report_error($sformatf("unexpected data_write in cycle %0d", cyc));
        end
        if (exp_write[cyc]) begin
            if (!data_write) begin
                report_error($sformatf("store at index %0d did not strobe in cycle %0d",
                                       st_idx[0], cyc));
            end else begin
                checks++;
                name = (st_idx[0] >= rand_len) ? "alu_store" : "store_data";
                if (data_addr !== st_addr[0])
                    report_mismatch("store_addr", st_addr[0], data_addr);
                if (data_mbe !== st_mbe[0])
                    report_mismatch("store_mask", {28'h0, st_mbe[0]}, {28'h0, data_mbe});
                if ((data_wdata & lane_bits(st_mbe[0])) !== st_data[0])
                    report_mismatch(name, st_data[0], data_wdata & lane_bits(st_mbe[0]));
            end
            void'(st_idx.pop_front());
            void'(st_addr.pop_front());
            void'(st_mbe.pop_front());
            void'(st_data.pop_front());
        end
        if (data_write) begin
            for (int l = 0; l < 4; l++) begin
                if (data_mbe[l])
                    dmem[data_addr[7:2]][8*l +: 8] = data_wdata[8*l +: 8];
            end
        end
    endtask

    initial begin
        inst_rdata = 32'h0;
        data_rdata = 32'h0;
        errors     = 0;
        checks     = 0;
        void'($urandom(32'h4b30efc5));
        for (int i = 0; i < 64; i++)
            dmem[i] = fill_word(i);
        gen_program();
        run_model();
        wait (rst_n === 1'b1);
        checks++;
        if (inst_addr !== rv32i_types::reset_pc)
            report_mismatch("reset_pc", rv32i_types::reset_pc, inst_addr);
        for (int cyc = 0; cyc < run_len; cyc++) begin
            if (cyc > 0 && inst_addr !== rv32i_types::reset_pc + 32'(4 * cyc))
                report_mismatch("fetch_pc", rv32i_types::reset_pc + 32'(4 * cyc), inst_addr);
            drive_memories();
            check_cycle(cyc);
            @(negedge clk);
        end
        if (st_idx.size() != 0)
            report_error($sformatf("%0d expected stores were never seen", st_idx.size()));
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

    // watchdog
    initial begin
        #(watchdog_ns);
        errors++;
        $display("Error: run did not finish within %0d ns", watchdog_ns);
        $display("checks: %0d, errors: %0d", checks, errors);
        $display("Testbench failed");
        $finish;
    end

endmodule
